//--- rtl/axi_rd_cfg.svh
`ifndef AXI_RD_CFG_SVH
`define AXI_RD_CFG_SVH

// --------------------------------------------------------------------------
// AXI field widths
// --------------------------------------------------------------------------

`define AXI_ID_WIDTH    4           // Transaction ID
`define AXI_ADDR_WIDTH  16          // Byte address
`define AXI_DATA_WIDTH  32          // Read data bus
`define AXI_LEN_WIDTH   8           // Burst length field
`define AXI_SIZE_WIDTH  3           // Beat size field

// --------------------------------------------------------------------------
// Read slave model behaviour
// --------------------------------------------------------------------------

// Number of reads the slave can hold at once
`define RD_OST_DEPTH    4

`define RD_MAX_BURST    8           // Beat buffer entries per slot

// A beat is fetched this many cycles minus the ID after the previous event
`define RD_FETCH_DLY    24

`define RD_ERR_ID       15          // Last beat of this ID gets SLVERR

`endif

//--- rtl/axi_pkg.sv
`include "axi_rd_cfg.svh"

package axi_pkg;

    // ----------------------------------------------------------------------
    // AXI field vectors
    // ----------------------------------------------------------------------

    typedef logic [`AXI_ID_WIDTH-1:0]   id_t;
    typedef logic [`AXI_ADDR_WIDTH-1:0] addr_t;
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_LEN_WIDTH-1:0]  len_t;       // Beats minus one
    typedef logic [`AXI_SIZE_WIDTH-1:0] size_t;      // Log2 of bytes per beat

    // ----------------------------------------------------------------------
    // Encoded fields
    // ----------------------------------------------------------------------

    typedef enum logic [1:0] {
        FIXED = 2'b00,                  // Same address every beat
        INCR  = 2'b01,                  // Address steps by beat size
        WRAP  = 2'b10                   // Served as FIXED in this model
    } burst_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } resp_e;

endpackage

//--- rtl/rd_slot_pkg.sv
`include "axi_rd_cfg.svh"

package rd_slot_pkg;

    // Index of one outstanding read slot
    typedef logic [$clog2(`RD_OST_DEPTH)-1:0] slot_idx_t;

    // Counts beats from 0 up to a full burst
    typedef logic [$clog2(`RD_MAX_BURST+1)-1:0] beat_cnt_t;

    // Fetch delay down-counter
    typedef logic [$clog2(`RD_FETCH_DLY+1)-1:0] fetch_cnt_t;

    typedef enum logic [1:0] {
        IDLE,                           // Free for a new request
        FETCH,                          // Beats still being fetched
        DRAIN,                          // All fetched, waiting for R
        RELEASE                         // One cycle before going free
    } slot_state_e;

endpackage

//--- rtl/rd_slot_alloc.sv
`include "axi_rd_cfg.svh"

module rd_slot_alloc (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      arvalid,
    input  logic [`RD_OST_DEPTH-1:0]  busy,
    output logic                      arready,
    output logic [`RD_OST_DEPTH-1:0]  load,
    output logic                      push,
    output rd_slot_pkg::slot_idx_t    push_idx
);

    localparam int DEPTH = `RD_OST_DEPTH;

    logic [DEPTH-1:0]       free;
    logic                   found;
    rd_slot_pkg::slot_idx_t pick;

    // A slot in RELEASE still shows busy, so it is never reloaded early
    assign free = ~busy;

    // ----------------------------------------------------------------------
    // Lowest-numbered free slot
    // ----------------------------------------------------------------------

    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (free[i] && !found) begin
                pick  = rd_slot_pkg::slot_idx_t'(i);
                found = 1'b1;
            end
        end
    end

    assign arready  = found;                // Any slot free
    assign push     = arvalid & arready;    // AR handshake
    assign push_idx = pick;
    assign load     = {{(DEPTH-1){1'b0}}, push} << pick;

endmodule

//--- rtl/rd_slot.sv
`include "axi_rd_cfg.svh"

module rd_slot (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load,
    input  axi_pkg::id_t      arid,
    input  axi_pkg::addr_t    araddr,
    input  axi_pkg::len_t     arlen,
    input  axi_pkg::size_t    arsize,
    input  axi_pkg::burst_e   arburst,
    input  logic              beat_take,
    output logic              busy,
    output logic              beat_avail,
    output axi_pkg::id_t      beat_id,
    output axi_pkg::data_t    beat_data,
    output axi_pkg::resp_e    beat_resp,
    output logic              beat_last
);

    localparam int BUF_AW = $clog2(`RD_MAX_BURST);

    rd_slot_pkg::slot_state_e state;
    rd_slot_pkg::slot_state_e state_nxt;

    // Captured request
    axi_pkg::id_t             id_q;
    axi_pkg::addr_t           addr_q;
    axi_pkg::len_t            len_q;
    axi_pkg::size_t           size_q;
    axi_pkg::burst_e          burst_q;

    rd_slot_pkg::fetch_cnt_t  fetch_cnt;    // Cycles left to next fetch
    rd_slot_pkg::beat_cnt_t   fetch_num;    // Beats written to the buffer
    rd_slot_pkg::beat_cnt_t   sent_num;     // Beats taken by the R channel
    rd_slot_pkg::beat_cnt_t   last_idx;

    logic                     fetch_now;
    logic                     fetch_done;
    logic                     send_done;
    axi_pkg::addr_t           aligned_addr;
    axi_pkg::addr_t           beat_addr;
    axi_pkg::data_t           beat_buf [`RD_MAX_BURST];

    assign last_idx   = rd_slot_pkg::beat_cnt_t'(len_q);
    assign fetch_now  = (state == rd_slot_pkg::FETCH) && (fetch_cnt == 1);
    assign fetch_done = fetch_now && (fetch_num == last_idx);
    assign send_done  = beat_take && (sent_num == last_idx);

    // ----------------------------------------------------------------------
    // Slot FSM
    // ----------------------------------------------------------------------

    always_comb begin
        state_nxt = state;
        case (state)
            rd_slot_pkg::IDLE:    if (load) state_nxt = rd_slot_pkg::FETCH;
            rd_slot_pkg::FETCH:   if (fetch_done) state_nxt = rd_slot_pkg::DRAIN;
            rd_slot_pkg::DRAIN:   if (send_done) state_nxt = rd_slot_pkg::RELEASE;
            rd_slot_pkg::RELEASE: state_nxt = rd_slot_pkg::IDLE;
            default:              state_nxt = rd_slot_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rd_slot_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Request fields, written only on acceptance
    always_ff @(posedge clk) begin
        if (load) begin
            id_q    <= arid;
            addr_q  <= araddr;
            len_q   <= arlen;
            size_q  <= arsize;
            burst_q <= arburst;
        end
    end

    // ----------------------------------------------------------------------
    // Fetch delay and beat counters
    // ----------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
            fetch_num <= '0;
            sent_num  <= '0;
        end else if (load) begin
            // Acceptance edge already spends one cycle of the delay
            fetch_cnt <= rd_slot_pkg::fetch_cnt_t'(`RD_FETCH_DLY - 1 - arid);
            fetch_num <= '0;
            sent_num  <= '0;
        end else begin
            if (fetch_now) begin
                fetch_cnt <= rd_slot_pkg::fetch_cnt_t'(`RD_FETCH_DLY - id_q);
                fetch_num <= fetch_num + 1'b1;
            end else if (state == rd_slot_pkg::FETCH) begin
                fetch_cnt <= fetch_cnt - 1'b1;
            end
            if (beat_take) begin
                sent_num <= sent_num + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Beat address and buffer
    // ----------------------------------------------------------------------

    assign aligned_addr = addr_q & ~((axi_pkg::addr_t'(1) << size_q) - axi_pkg::addr_t'(1));

    always_comb begin
        beat_addr = addr_q;                 // FIXED and WRAP repeat the start
        if (burst_q == axi_pkg::INCR && fetch_num != 0) begin
            beat_addr = aligned_addr + (axi_pkg::addr_t'(fetch_num) << size_q);
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_now) begin
            beat_buf[fetch_num[BUF_AW-1:0]] <= axi_pkg::data_t'({id_q, beat_addr});
        end
    end

    assign busy       = (state != rd_slot_pkg::IDLE);
    assign beat_avail = (fetch_num > sent_num);     // Buffered and unsent
    assign beat_id    = id_q;
    assign beat_data  = beat_buf[sent_num[BUF_AW-1:0]];
    assign beat_last  = (sent_num == last_idx);
    assign beat_resp  = (beat_last && id_q == axi_pkg::id_t'(`RD_ERR_ID)) ?
                        axi_pkg::SLVERR : axi_pkg::OKAY;

endmodule

//--- rtl/rd_resp_seq.sv
`include "axi_rd_cfg.svh"

module rd_resp_seq (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      push,
    input  rd_slot_pkg::slot_idx_t    push_idx,
    input  logic [`RD_OST_DEPTH-1:0]  beat_avail,
    input  axi_pkg::id_t              beat_id   [`RD_OST_DEPTH],
    input  axi_pkg::data_t            beat_data [`RD_OST_DEPTH],
    input  axi_pkg::resp_e            beat_resp [`RD_OST_DEPTH],
    input  logic [`RD_OST_DEPTH-1:0]  beat_last,
    input  logic                      rready,
    output logic                      rvalid,
    output axi_pkg::id_t              rid,
    output axi_pkg::data_t            rdata,
    output axi_pkg::resp_e            rresp,
    output logic                      rlast,
    output logic [`RD_OST_DEPTH-1:0]  beat_take
);

    localparam int DEPTH = `RD_OST_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    rd_slot_pkg::slot_idx_t order_q [DEPTH];    // Slot indices in AR order
    logic [PW:0]            wr_ptr;             // Extra bit tells full from empty
    logic [PW:0]            rd_ptr;
    logic                   empty;
    logic                   take;
    logic                   pop;
    rd_slot_pkg::slot_idx_t head;

    // ----------------------------------------------------------------------
    // Acceptance-order FIFO
    // ----------------------------------------------------------------------

    assign empty = (wr_ptr == rd_ptr);
    assign head  = order_q[rd_ptr[PW-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            order_q[wr_ptr[PW-1:0]] <= push_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // R channel from the head slot
    // ----------------------------------------------------------------------

    assign rvalid    = !empty && beat_avail[head];
    assign rid       = beat_id[head];
    assign rdata     = beat_data[head];
    assign rresp     = beat_resp[head];
    assign rlast     = rvalid && beat_last[head];

    assign take      = rvalid && rready;            // R handshake
    assign pop       = take && rlast;               // Burst finished
    assign beat_take = {{(DEPTH-1){1'b0}}, take} << head;

endmodule

//--- rtl/axi_rd_slave.sv
`include "axi_rd_cfg.svh"

module axi_rd_slave (
    input  logic             clk,
    input  logic             rst_n,
    // AR channel
    input  logic             arvalid,
    output logic             arready,
    input  axi_pkg::id_t     arid,
    input  axi_pkg::addr_t   araddr,
    input  axi_pkg::len_t    arlen,
    input  axi_pkg::size_t   arsize,
    input  axi_pkg::burst_e  arburst,
    // R channel
    output logic             rvalid,
    input  logic             rready,
    output axi_pkg::id_t     rid,
    output axi_pkg::data_t   rdata,
    output axi_pkg::resp_e   rresp,
    output logic             rlast
);

    localparam int DEPTH = `RD_OST_DEPTH;

    logic [DEPTH-1:0]       slot_busy;
    logic [DEPTH-1:0]       slot_load;      // One-hot capture strobe
    logic                   push;
    rd_slot_pkg::slot_idx_t push_idx;

    logic [DEPTH-1:0]       beat_avail;
    logic [DEPTH-1:0]       beat_last;
    logic [DEPTH-1:0]       beat_take;      // One-hot from the sequencer
    axi_pkg::id_t           beat_id   [DEPTH];
    axi_pkg::data_t         beat_data [DEPTH];
    axi_pkg::resp_e         beat_resp [DEPTH];

    rd_slot_alloc u_alloc (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (arvalid),
        .busy     (slot_busy),
        .arready  (arready),
        .load     (slot_load),
        .push     (push),
        .push_idx (push_idx)
    );

    // ----------------------------------------------------------------------
    // Outstanding read slots
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        rd_slot u_slot (
            .clk        (clk),
            .rst_n      (rst_n),
            .load       (slot_load[i]),
            .arid       (arid),
            .araddr     (araddr),
            .arlen      (arlen),
            .arsize     (arsize),
            .arburst    (arburst),
            .beat_take  (beat_take[i]),
            .busy       (slot_busy[i]),
            .beat_avail (beat_avail[i]),
            .beat_id    (beat_id[i]),
            .beat_data  (beat_data[i]),
            .beat_resp  (beat_resp[i]),
            .beat_last  (beat_last[i])
        );
    end

    rd_resp_seq u_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_idx   (push_idx),
        .beat_avail (beat_avail),
        .beat_id    (beat_id),
        .beat_data  (beat_data),
        .beat_resp  (beat_resp),
        .beat_last  (beat_last),
        .rready     (rready),
        .rvalid     (rvalid),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .beat_take  (beat_take)
    );

endmodule

//--- verification/axi_rd_slave_properties.sv
module axi_rd_slave_properties (
    input logic            clk,
    input logic            rst_n,
    input logic            arready,
    input logic            rvalid,
    input logic            rready,
    input axi_pkg::id_t    rid,
    input axi_pkg::data_t  rdata,
    input axi_pkg::resp_e  rresp,
    input logic            rlast
);

    timeunit 1ns;
    timeprecision 1ps;

    // --------------------------------------------------------------------------
    // R channel
    // --------------------------------------------------------------------------

    // Stalled beat keeps its payload
    r_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid)
                              && $stable(rlast) && $stable(rresp))
        else $error("R beat changed while stalled");

    r_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> !rvalid)
        else $error("rvalid high in the first cycle after reset");

    r_last_a: assert property (@(posedge clk) disable iff (!rst_n) rlast |-> rvalid)
        else $error("rlast high without rvalid");

    // All slots are free out of reset
    ar_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> arready)
        else $error("arready low in the first cycle after reset");

endmodule

bind axi_rd_slave axi_rd_slave_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .arready (arready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast)
);

//--- verification/axi_rd_slave_tb.sv
`include "axi_rd_cfg.svh"

module axi_rd_slave_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam string PATTERN_FILE = "verification/axi_rd_patterns.txt";
    localparam int    CLK_PERIOD   = 8;
    localparam int    WDOG_MARGIN  = 2000;         // ns on top of the worst case

    logic              clk = 1'b0;
    logic              rst_n;
    logic              arvalid;
    logic              arready;
    axi_pkg::id_t      arid;
    axi_pkg::addr_t    araddr;
    axi_pkg::len_t     arlen;
    axi_pkg::size_t    arsize;
    axi_pkg::burst_e   arburst;
    logic              rvalid;
    logic              rready = 1'b0;
    axi_pkg::id_t      rid;
    axi_pkg::data_t    rdata;
    axi_pkg::resp_e    rresp;
    logic              rlast;

    // Requests as read from the pattern file
    axi_pkg::id_t      rq_id    [$];
    axi_pkg::addr_t    rq_addr  [$];
    axi_pkg::len_t     rq_len   [$];
    axi_pkg::size_t    rq_size  [$];
    axi_pkg::burst_e   rq_burst [$];

    // Expected beats, oldest first
    axi_pkg::id_t      ex_id    [$];
    axi_pkg::data_t    ex_data  [$];
    axi_pkg::resp_e    ex_resp  [$];
    logic              ex_last  [$];

    int                n_req;
    int                err_value;                  // Wrong R field values
    int                err_extra;                  // Beats with nothing expected
    int                err_other;
    bit                saw_full;                   // arready seen low under arvalid
    bit                loaded;
    integer            seed = 16;

    axi_rd_slave UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // --------------------------------------------------------------------------
    // Pattern file and AR driver
    // --------------------------------------------------------------------------

    task read_patterns;
        integer       fd;
        integer       code;
        string        line;
        logic [31:0]  f [5];
        axi_pkg::id_t cur_id;
        fd     = $fopen(PATTERN_FILE, "r");
        cur_id = '0;
        if (fd == 0) begin
            $display("Cannot open the pattern file %s", PATTERN_FILE);
            err_other++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                code = $fgets(line, fd);
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;                      // Blank or column notes
                end
                if (line.getc(0) == "A") begin
                    code = $sscanf(line, "A %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                    if (code != 5) begin
                        $display("Malformed request line in the pattern file: %s", line);
                        err_other++;
                    end else begin
                        cur_id = axi_pkg::id_t'(f[0]);
                        rq_id.push_back(cur_id);
                        rq_addr.push_back(axi_pkg::addr_t'(f[1]));
                        rq_len.push_back(axi_pkg::len_t'(f[2]));
                        rq_size.push_back(axi_pkg::size_t'(f[3]));
                        rq_burst.push_back(axi_pkg::burst_e'(f[4][1:0]));
                    end
                end else if (line.getc(0) == "R") begin
                    code = $sscanf(line, "R %h %h %h", f[0], f[1], f[2]);
                    if (code != 3) begin
                        $display("Malformed beat line in the pattern file: %s", line);
                        err_other++;
                    end else begin
                        // Requests go out in file order, which is acceptance order
                        ex_id.push_back(cur_id);
                        ex_data.push_back(axi_pkg::data_t'(f[0]));
                        ex_resp.push_back(axi_pkg::resp_e'(f[1][1:0]));
                        ex_last.push_back(f[2][0]);
                    end
                end else begin
                    $display("Unknown line in the pattern file: %s", line);
                    err_other++;
                end
            end
            $fclose(fd);
        end
        n_req = rq_id.size();
    endtask

    // Starts on a rising edge, returns on the handshake edge
    task send_request(input int i);
        arvalid <= 1'b1;
        arid    <= rq_id[i];
        araddr  <= rq_addr[i];
        arlen   <= rq_len[i];
        arsize  <= rq_size[i];
        arburst <= rq_burst[i];
        @(negedge clk);
        while (!arready) begin
            saw_full = 1'b1;                       // Every slot held
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // --------------------------------------------------------------------------
    // R channel checks
    // --------------------------------------------------------------------------

    task compare_id(input string name, input axi_pkg::id_t got, input axi_pkg::id_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            err_value++;
        end
    endtask

    task compare_data(input string name, input axi_pkg::data_t got,
                      input axi_pkg::data_t exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            err_value++;
        end
    endtask

    task compare_resp(input string name, input axi_pkg::resp_e got,
                      input axi_pkg::resp_e exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            err_value++;
        end
    endtask

    task compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            err_value++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            rready <= (($random(seed) & 3) != 0);  // Ready about three cycles in four
        end
    end

    // Mid-cycle sample, the transfer happens on the next rising edge
    always @(negedge clk) begin
        if (rst_n && rvalid && rready) begin
            if (ex_data.size() == 0) begin
                $display("R beat at %0d ns arrived with no beat outstanding", $time);
                err_extra++;
            end else begin
                compare_id("rid", rid, ex_id.pop_front());
                compare_data("rdata", rdata, ex_data.pop_front());
                compare_resp("rresp", rresp, ex_resp.pop_front());
                compare_flag("rlast", rlast, ex_last.pop_front());
            end
        end
    end

    initial begin
        wait (loaded);
        #(n_req * `RD_MAX_BURST * `RD_FETCH_DLY * CLK_PERIOD + WDOG_MARGIN);
        $display("Watchdog expired with %0d beats still expected", ex_data.size());
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        arvalid = 1'b0;
        arid    = '0;
        araddr  = '0;
        arlen   = '0;
        arsize  = '0;
        arburst = axi_pkg::FIXED;
        read_patterns();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_req; i++) begin
            send_request(i);
        end
        arvalid <= 1'b0;
        while (ex_data.size() != 0) @(posedge clk);
        repeat (4) @(posedge clk);                 // Catch any trailing beat
        if (!saw_full) begin
            $display("arready never dropped while all slots were busy");
            err_other++;
        end
        $display("Error counts: %0d value, %0d unexpected beat, %0d other",
                 err_value, err_extra, err_other);
        if (err_value + err_extra + err_other == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- verification/axi_rd_patterns.txt
# A id addr len size burst : AR request, hex, burst 0 FIXED 1 INCR
# R data resp last         : expected beat of the request above, hex, resp 0 OKAY 2 SLVERR
A 1 0102 02 2 1
R 00010102 0 0
R 00010104 0 0
R 00010108 0 1
A 3 0207 01 0 0
R 00030207 0 0
R 00030207 0 1
A f 0301 01 1 1
R 000f0301 0 0
R 000f0302 2 1
A 9 0400 00 2 1
R 00090400 0 1
A 2 0513 01 3 1
R 00020513 0 0
R 00020518 0 1
A f 0600 00 2 0
R 000f0600 2 1

//--- axi_rd_slave.f
+incdir+rtl
rtl/axi_pkg.sv
rtl/rd_slot_pkg.sv
rtl/rd_slot_alloc.sv
rtl/rd_slot.sv
rtl/rd_resp_seq.sv
rtl/axi_rd_slave.sv
verification/axi_rd_slave_properties.sv
verification/axi_rd_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f axi_rd_slave.f --top-module axi_rd_slave_tb

status=0
./obj_dir/Vaxi_rd_slave_tb > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
